//--- divPkg.sv
// Divide unit shared types
package divPkg;

    // operation code width, fixed by the instruction encoding
    localparam int divOpWidth = 2;

    // operation code carried with each request
    typedef logic [divOpWidth-1:0] divOpT;

    // signed quotient, rounds toward zero
    localparam divOpT DIV_OP_DIV  = 2'd0;
    // unsigned quotient
    localparam divOpT DIV_OP_DIVU = 2'd1;
    // signed remainder, takes the dividend's sign
    localparam divOpT DIV_OP_REM  = 2'd2;
    // unsigned remainder
    localparam divOpT DIV_OP_REMU = 2'd3;

    // core sequencing states
    //   idle  waiting for a start pulse
    //   setup pre-shift divisor and quotient weight
    //   iter  retire quotient bits each cycle
    //   done  hold results until ack
    typedef enum logic [1:0] {
        DIV_IDLE  = 2'd0,
        DIV_SETUP = 2'd1,
        DIV_ITER  = 2'd2,
        DIV_DONE  = 2'd3
    } divCoreStateT;

endpackage

//--- divSignCtrl.sv
// Divide sign and special case control
`timescale 1ns/1ns

module divSignCtrl #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 ack,
    input  divPkg::divOpT        op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic                 coreStart,
    output logic                 coreAck,
    output logic [dataWidth-1:0] coreA,
    output logic [dataWidth-1:0] coreB,
    input  logic [dataWidth-1:0] coreQ,
    input  logic [dataWidth-1:0] coreR,
    input  logic                 coreComplete,
    output logic [dataWidth-1:0] result,
    output logic                 complete
);

    import divPkg::*;

    // request decode on the start cycle
    logic signedOp;
    logic aNeg;
    logic bNeg;
    logic bZero;
    logic [dataWidth-1:0] absA;
    logic [dataWidth-1:0] absB;

    // captured with the request
    divOpT opReg;
    logic  aNegReg;
    logic  qNegReg;
    logic  zeroDivReg;
    logic  zeroDone;

    // result shaping
    logic isRem;
    logic [dataWidth-1:0] quoFixed;
    logic [dataWidth-1:0] remSource;
    logic [dataWidth-1:0] remFixed;

    assign signedOp = (op == DIV_OP_DIV) || (op == DIV_OP_REM);
    assign aNeg     = signedOp & a[dataWidth-1];
    assign bNeg     = signedOp & b[dataWidth-1];
    assign bZero    = (b == '0);

    // two's complement magnitude
    // most negative value maps onto itself as an unsigned magnitude
    assign absA = aNeg ? -a : a;
    assign absB = bNeg ? -b : b;

    // request fields held for the result fixup
    always_ff @(posedge clk) begin
        if (start) begin
            opReg      <= op;
            aNegReg    <= aNeg;
            qNegReg    <= aNeg ^ bNeg;
            zeroDivReg <= bZero;
            coreA      <= absA;
            coreB      <= absB;
        end
    end

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            coreStart <= 1'b0;
            zeroDone  <= 1'b0;
        end else begin
            // core never runs on a zero divisor
            coreStart <= start & ~bZero;
            if (start && bZero) begin
                zeroDone <= 1'b1;
            end else if (ack) begin
                zeroDone <= 1'b0;
            end
        end
    end

    assign coreAck = ack;

    assign isRem = (opReg == DIV_OP_REM) || (opReg == DIV_OP_REMU);

    // zero divisor quotient is all ones whatever the signs
    always_comb begin
        if (zeroDivReg) begin
            quoFixed = '1;
        end else if (qNegReg) begin
            quoFixed = -coreQ;
        end else begin
            quoFixed = coreQ;
        end
    end

    // zero divisor remainder is the dividend rebuilt from its magnitude
    assign remSource = zeroDivReg ? coreA : coreR;
    assign remFixed  = aNegReg ? -remSource : remSource;

    assign result   = isRem ? remFixed : quoFixed;
    assign complete = zeroDone | coreComplete;

endmodule

//--- divUnit.sv
// Integer divide unit
`timescale 1ns/1ns

module divUnit #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 ack,
    input  divPkg::divOpT        op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] result,
    output logic                 complete
);

    // controller to core
    logic                 coreStart;
    logic                 coreAck;
    logic [dataWidth-1:0] coreA;
    logic [dataWidth-1:0] coreB;

    // core to controller
    logic [dataWidth-1:0] coreQ;
    logic [dataWidth-1:0] coreR;
    logic                 coreComplete;

    // signs, zero divisor and result fixup
    divSignCtrl #(
        .dataWidth(dataWidth)
    ) signCtrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .ack         (ack),
        .op          (op),
        .a           (a),
        .b           (b),
        .coreStart   (coreStart),
        .coreAck     (coreAck),
        .coreA       (coreA),
        .coreB       (coreB),
        .coreQ       (coreQ),
        .coreR       (coreR),
        .coreComplete(coreComplete),
        .result      (result),
        .complete    (complete)
    );

    // unsigned magnitude divider
    quickDivCore #(
        .dataWidth(dataWidth)
    ) core (
        .clk     (clk),
        .rst     (rst),
        .start   (coreStart),
        .ack     (coreAck),
        .a       (coreA),
        .b       (coreB),
        .q       (coreQ),
        .r       (coreR),
        .complete(coreComplete)
    );

endmodule

//--- divUnit_asserts.sv
// Divide unit protocol assertions
`timescale 1ns/1ns

module divUnit_asserts #(
    parameter int dataWidth = 32
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 ack,
    input logic                 complete,
    input logic [dataWidth-1:0] result,
    input divPkg::divCoreStateT coreState
);

    import divPkg::*;

    // per property failure tallies, summed by the testbench
    int resetFails   = 0;
    int holdFails    = 0;
    int stableFails  = 0;
    int releaseFails = 0;
    int startFails   = 0;

    // nothing pending coming out of reset
    resetClear: assert property (@(posedge clk) rst |=> !complete)
        else begin
            resetFails++;
            $error("complete high in the cycle after reset");
        end

    // complete only drops after ack
    completeHold: assert property (@(posedge clk) disable iff (rst)
        complete && !ack |=> complete)
        else begin
            holdFails++;
            $error("complete fell without ack");
        end

    // result frozen under back-pressure
    resultStable: assert property (@(posedge clk) disable iff (rst)
        complete && !ack |=> $stable(result))
        else begin
            stableFails++;
            $error("result changed while waiting for ack");
        end

    // ack releases the result in one cycle
    ackRelease: assert property (@(posedge clk) disable iff (rst)
        complete && ack |=> !complete)
        else begin
            releaseFails++;
            $error("complete still high the cycle after ack");
        end

    // no new request while busy or holding a result
    startLegal: assert property (@(posedge clk) disable iff (rst)
        start |-> !complete && coreState == DIV_IDLE)
        else begin
            startFails++;
            $error("start while a division is running or pending");
        end

endmodule

//--- divUnit_tb.sv
// Divide unit testbench
`timescale 1ns/1ns

module divUnit_tb;

    import divPkg::*;

    localparam int dataWidth   = 32;
    localparam int numOps      = 2000;
    localparam int resetCycles = 5;
    // longest expected operation, over the whole run
    localparam int cycleLimit  = numOps * (dataWidth + 12) + resetCycles;

    typedef logic [dataWidth-1:0] dataT;

    localparam dataT minNeg = {1'b1, {(dataWidth-1){1'b0}}};

    // stimulus modes
    localparam int modeUnsigned   = 0;
    localparam int modeSigned     = 1;
    localparam int modeZeroDiv    = 2;
    localparam int modeHold       = 3;
    localparam int modeBackToBack = 4;

    logic  clk;
    logic  rst;
    logic  start;
    logic  ack;
    divOpT op;
    dataT  a;
    dataT  b;
    dataT  result;
    logic  complete;

    logic [31:0] rngState;
    int errors;
    int checks;
    int assertFails;
    int cycleCount = 0;

    tbClock #(
        .resetCycles(resetCycles)
    ) clockGen (
        .clk(clk),
        .rst(rst)
    );

    divUnit #(
        .dataWidth(dataWidth)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .ack     (ack),
        .op      (op),
        .a       (a),
        .b       (b),
        .result  (result),
        .complete(complete)
    );

    bind divUnit divUnit_asserts #(
        .dataWidth(dataWidth)
    ) protocolChecks (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .ack      (ack),
        .complete (complete),
        .result   (result),
        .coreState(core.state)
    );

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run went past %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // RISC-V M extension rules
    function automatic dataT modelResult(input divOpT opIn, input dataT x, input dataT y);
        logic isQuo;
        isQuo = (opIn == DIV_OP_DIV) || (opIn == DIV_OP_DIVU);
        if (y == '0) begin
            return isQuo ? '1 : x;
        end
        if (opIn == DIV_OP_DIVU) begin
            return x / y;
        end
        if (opIn == DIV_OP_REMU) begin
            return x % y;
        end
        // signed overflow
        if (x == minNeg && y == '1) begin
            return isQuo ? x : '0;
        end
        // truncating division, remainder follows the dividend
        if (isQuo) begin
            return dataT'($signed(x) / $signed(y));
        end
        return dataT'($signed(x) % $signed(y));
    endfunction

    task automatic checkResult(input divOpT opIn, input dataT x, input dataT y,
                               input dataT expected, input dataT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t: op %0d a %h b %h gave %h, expected %h",
                     $time, opIn, x, y, actual, expected);
        end
    endtask

    task automatic checkHold(input dataT first, input dataT now, input logic completeNow);
        checks++;
        if (completeNow !== 1'b1) begin
            errors++;
            $display("FAIL t=%0t: complete dropped while ack withheld", $time);
        end else if (now !== first) begin
            errors++;
            $display("FAIL t=%0t: result moved from %h to %h before ack", $time, first, now);
        end
    endtask

    task automatic checkLatency(input logic zeroDiv, input int cycles);
        checks++;
        if (zeroDiv && cycles != 1) begin
            errors++;
            $display("FAIL t=%0t: zero divisor took %0d cycles, expected 1", $time, cycles);
        end else if (!zeroDiv && cycles < 2) begin
            errors++;
            $display("FAIL t=%0t: division took %0d cycles, expected 2 or more", $time, cycles);
        end
    endtask

    task automatic checkRelease(input logic completeNow);
        checks++;
        if (completeNow !== 1'b0) begin
            errors++;
            $display("FAIL t=%0t: complete still high the cycle after ack", $time);
        end
    endtask

    task automatic pickOperands(input int mode, output divOpT opOut,
                                output dataT x, output dataT y);
        logic [31:0] kind;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0   = nextRandom();
        r1   = nextRandom();
        r2   = nextRandom();
        kind = nextRandom() % 16;
        x = r0;
        // spread divisor sizes so run lengths vary
        y = r1 >> (r2 % dataWidth);
        case (kind)
            0, 1: y = '0;
            2: begin
                y = (r2 % 8) + 1;
                if (r1[0]) begin
                    y = -y;
                end
            end
            3: y = x;
            4: begin
                x = minNeg;
                if (r1[1]) begin
                    y = '1;
                end
            end
            5: x = y >> ((r2 % 4) + 1);
            6: y = 1;
            7: y = '1;
            default: ;
        endcase
        opOut = divOpT'(nextRandom() % 4);
        // bit zero of the op code marks the unsigned forms
        if (mode == modeUnsigned) begin
            opOut[0] = 1'b1;
        end else if (mode == modeSigned) begin
            opOut[0] = 1'b0;
        end else if (mode == modeZeroDiv) begin
            y = '0;
        end
    endtask

    // one request, from start through ack
    task automatic runOne(input int mode);
        divOpT opSel;
        dataT  x;
        dataT  y;
        dataT  expected;
        dataT  first;
        int    ackDelay;
        int    gap;
        int    latency;
        pickOperands(mode, opSel, x, y);
        expected = modelResult(opSel, x, y);
        ackDelay = (mode == modeHold) ? 1 + int'(nextRandom() % 8) : int'(nextRandom() % 9);
        gap      = (mode == modeBackToBack) ? 0 : int'(nextRandom() % 3);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        start <= 1'b1;
        op    <= opSel;
        a     <= x;
        b     <= y;
        @(posedge clk);
        start <= 1'b0;
        // cycles counted from the edge that took start
        latency = 1;
        @(negedge clk);
        while (!complete) begin
            @(negedge clk);
            latency++;
        end
        first = result;
        checkResult(opSel, x, y, expected, first);
        checkLatency(y == '0, latency);
        repeat (ackDelay) begin
            @(negedge clk);
            checkHold(first, result, complete);
        end
        @(posedge clk);
        ack <= 1'b1;
        @(posedge clk);
        ack <= 1'b0;
        @(negedge clk);
        checkRelease(complete);
    endtask

    task automatic runTest(input string name, input int mode, input int count);
        int errorsBefore;
        errorsBefore = errors;
        for (int i = 0; i < count; i++) begin
            runOne(mode);
        end
        $display("test %s: %0d operations, %0d errors", name, count, errors - errorsBefore);
    endtask

    initial begin
        rngState = 32'd17656;
        errors   = 0;
        checks   = 0;
        start <= 1'b0;
        ack   <= 1'b0;
        op    <= DIV_OP_DIV;
        a     <= '0;
        b     <= '0;
        @(negedge clk);
        while (rst !== 1'b0) begin
            @(negedge clk);
        end
        runTest("unsigned ops", modeUnsigned, 400);
        runTest("signed ops", modeSigned, 400);
        runTest("zero divisor", modeZeroDiv, 200);
        runTest("back-pressure", modeHold, 400);
        runTest("back-to-back", modeBackToBack, 600);
        assertFails = dut.protocolChecks.resetFails + dut.protocolChecks.holdFails
                    + dut.protocolChecks.stableFails + dut.protocolChecks.releaseFails
                    + dut.protocolChecks.startFails;
        errors += assertFails;
        $display("tests: 5, checks: %0d, assertion failures: %0d, errors: %0d",
                 checks, assertFails, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- msbDetect.sv
// Leading one position finder
`timescale 1ns/1ns

module msbDetect #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0]         value,
    output logic [$clog2(dataWidth)-1:0] msb
);

    // index width, enough to name every bit of value
    localparam int msbWidth = $clog2(dataWidth);

    // lowest to highest scan, so the last hit is the top set bit
    // a zero input falls through and reports index zero
    always_comb begin
        msb = '0;
        for (int i = 0; i < dataWidth; i++) begin
            if (value[i]) begin
                msb = msbWidth'(i);
            end
        end
    end

endmodule

//--- quickDivCore.sv
// Early terminating unsigned divider
`timescale 1ns/1ns

module quickDivCore #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 ack,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] q,
    output logic [dataWidth-1:0] r,
    output logic                 complete
);

    import divPkg::*;

    localparam int msbWidth = $clog2(dataWidth);

    divCoreStateT state;

    // running remainder, partial quotient and held divisor
    logic [dataWidth-1:0] remReg;
    logic [dataWidth-1:0] quoReg;
    logic [dataWidth-1:0] divisorReg;

    // leading one positions
    logic [msbWidth-1:0] remMsb;
    logic [msbWidth-1:0] divisorMsb;
    logic [msbWidth-1:0] divisorMsbReg;

    // divisor and weight parked in the upper half, pushed right by the divisor msb
    logic [2*dataWidth-1:0] shiftedDivisor;
    logic [2*dataWidth-1:0] shiftedWeight;
    logic [2*dataWidth-1:0] alignedDivisorWide;
    logic [2*dataWidth-1:0] alignedWeightWide;

    // first trial: divisor msb under remainder msb
    logic [dataWidth-1:0] trialDivisor1;
    logic [dataWidth-1:0] trialWeight1;
    logic [dataWidth:0]   trialDiff1;
    // second trial: one position lower
    logic [dataWidth-1:0] trialDivisor2;
    logic [dataWidth-1:0] trialWeight2;
    logic [dataWidth-1:0] trialDiff2;

    logic borrow;
    logic terminate;
    logic [dataWidth-1:0] nextRem;
    logic [dataWidth-1:0] nextQuo;

    // remainder msb changes every iteration
    msbDetect #(
        .dataWidth(dataWidth)
    ) remMsbDetect (
        .value(remReg),
        .msb  (remMsb)
    );

    // divisor msb taken straight off the input at start
    msbDetect #(
        .dataWidth(dataWidth)
    ) divisorMsbDetect (
        .value(b),
        .msb  (divisorMsb)
    );

    // left shift by remainder msb, upper half gives divisor << (remMsb - divisorMsb)
    assign alignedDivisorWide = shiftedDivisor << remMsb;
    assign alignedWeightWide  = shiftedWeight << remMsb;
    assign trialDivisor1      = alignedDivisorWide[2*dataWidth-1:dataWidth];
    assign trialWeight1       = alignedWeightWide[2*dataWidth-1:dataWidth];

    // halved fallback if the aligned divisor overshoots
    assign trialDivisor2 = {1'b0, trialDivisor1[dataWidth-1:1]};
    assign trialWeight2  = {1'b0, trialWeight1[dataWidth-1:1]};

    // extra top bit catches the borrow
    assign trialDiff1 = {1'b0, remReg} - {1'b0, trialDivisor1};
    assign trialDiff2 = remReg - trialDivisor2;
    assign borrow     = trialDiff1[dataWidth];

    assign nextRem = borrow ? trialDiff2 : trialDiff1[dataWidth-1:0];
    assign nextQuo = quoReg | (borrow ? trialWeight2 : trialWeight1);

    // nothing left to subtract
    assign terminate = remReg < divisorReg;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_SETUP;
                    end
                end
                DIV_SETUP: begin
                    state <= DIV_ITER;
                end
                DIV_ITER: begin
                    if (terminate) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    // results held until the consumer takes them
                    if (ack) begin
                        state <= DIV_IDLE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            remReg        <= a;
            quoReg        <= '0;
            divisorReg    <= b;
            divisorMsbReg <= divisorMsb;
        end
        if (state == DIV_SETUP) begin
            shiftedDivisor <= {divisorReg, {dataWidth{1'b0}}} >> divisorMsbReg;
            // one-hot weight of bit zero, moved by the same amount
            shiftedWeight  <= {{(dataWidth-1){1'b0}}, 1'b1, {dataWidth{1'b0}}} >> divisorMsbReg;
        end
        if (state == DIV_ITER && !terminate) begin
            remReg <= nextRem;
            quoReg <= nextQuo;
        end
    end

    assign q        = quoReg;
    assign r        = remReg;
    assign complete = (state == DIV_DONE);

endmodule

//--- run.sh
#!/bin/sh
# compile and run the divide unit testbench with Verilator
set -e

cd "$(dirname "$0")"

# fresh build of the testbench top
rm -rf obj_dir
verilator --binary --timing --assert --top-module divUnit_tb -f tb.f -o simDivUnit

# error limit raised so assertion failures still reach the summary line
./obj_dir/simDivUnit +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb.f
divPkg.sv
msbDetect.sv
quickDivCore.sv
divSignCtrl.sv
divUnit.sv
tbClock.sv
divUnit_asserts.sv
divUnit_tb.sv

//--- tbClock.sv
// Testbench clock and reset
`timescale 1ns/1ns

module tbClock #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    // synchronous reset, dropped on a rising edge
    initial begin
        rst <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
